// File: exu_macros.svh
`ifndef EXU_MACROS_SVH
`define EXU_MACROS_SVH

// Datapath and address widths.
`define XLEN             32
`define VADDR_SIZE       32
`define DEC_IMM_WIDTH    20
`define INTOP_WIDTH      4
`define BRANCHOP_WIDTH   3
`define PREDICTION_WIDTH 3
`define ROB_WIDTH        5
`define REG_WIDTH        5
`define EXC_WIDTH        4
`define BR_TYPE_WIDTH    2
`define RAS_TYPE_WIDTH   2

// Integer op codes.
`define INT_ADD   4'd0
`define INT_SUB   4'd1
`define INT_LUI   4'd2
`define INT_SLT   4'd3
`define INT_OR    4'd4
`define INT_XOR   4'd5
`define INT_AND   4'd6
`define INT_SL    4'd7
`define INT_SR    4'd8
`define INT_AUIPC 4'd9

// Branch op codes.
`define BRANCH_BEQ  3'd0
`define BRANCH_BNE  3'd1
`define BRANCH_BLT  3'd2
`define BRANCH_BGE  3'd3
`define BRANCH_JAL  3'd4
`define BRANCH_JALR 3'd5

`define EXC_NONE 4'd0

`endif

// File: exu_pkg.sv
`default_nettype none

`include "exu_macros.svh"

package exu_pkg;

    typedef logic [`XLEN-1:0]             xlen_t;
    typedef logic [`VADDR_SIZE-1:0]       vaddr_t;
    typedef logic [`DEC_IMM_WIDTH-1:0]    imm_t;
    typedef logic [`ROB_WIDTH-1:0]        rob_idx_t;
    typedef logic [`REG_WIDTH-1:0]        reg_idx_t;
    typedef logic [`PREDICTION_WIDTH-1:0] offset_t;
    typedef logic [`INTOP_WIDTH-1:0]      intop_t;
    typedef logic [`BRANCHOP_WIDTH-1:0]   branchop_t;
    typedef logic [`EXC_WIDTH-1:0]        exccode_t;
    typedef logic [`BR_TYPE_WIDTH-1:0]    br_type_t;
    typedef logic [`RAS_TYPE_WIDTH-1:0]   ras_type_t;

    // Predicted exit of one fetch block.
    typedef struct packed {
        logic    taken;
        offset_t size;      // Slot of the predicted exit.
        vaddr_t  target;
    } fetch_stream_t;

    typedef struct packed {
        logic          intv;       // Integer op when set, else branch.
        logic          immv;
        logic          uext;
        imm_t          imm;
        intop_t        intop;
        branchop_t     branchop;
        offset_t       offset;     // Slot of this op in its fetch block.
        logic          we;
        rob_idx_t      rob_idx;
        reg_idx_t      rd;
        xlen_t         rs1_data;
        xlen_t         rs2_data;
        vaddr_t        vaddr;
        fetch_stream_t stream;
        br_type_t      br_type;
        ras_type_t     ras_type;
    } exu_bundle_t;

    typedef struct packed {
        logic     en;
        logic     we;
        rob_idx_t rob_idx;
        reg_idx_t rd;
        xlen_t    res;
        exccode_t exccode;
    } wb_data_t;

    typedef struct packed {
        logic      direction;
        vaddr_t    target;
        logic      error;      // Prediction was wrong.
        br_type_t  br_type;
        ras_type_t ras_type;
    } branch_res_t;

endpackage

`default_nettype wire

// File: issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                issue_valid,
    input  exu_pkg::exu_bundle_t issue_bundle,
    input  logic                flush,
    output logic                ex_valid,
    output exu_pkg::exu_bundle_t ex_bundle
);

    logic load;
    logic valid_q;

    // A flushed op is dropped at the edge it arrives.
    assign load = issue_valid & ~flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= load;
        end
    end

    // The op held here dies too, before write-back can take it.
    assign ex_valid = valid_q & ~flush;

    // Payload holds over idle cycles.
    always_ff @(posedge clk) begin
        if (load) begin
            ex_bundle <= issue_bundle;
        end
    end

endmodule

`default_nettype wire

// File: int_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_macros.svh"

module int_alu (
    input  exu_pkg::exu_bundle_t ex_bundle,
    output exu_pkg::xlen_t       alu_result
);
    import exu_pkg::*;

    localparam int SHAMT_W = $clog2(`XLEN);

    xlen_t lui_imm;
    xlen_t s_imm;
    xlen_t z_imm;
    xlen_t op_imm;
    xlen_t data1;
    xlen_t data2;
    xlen_t add_result;
    xlen_t sub_result;
    xlen_t sl_data;
    xlen_t sr_data;
    logic [SHAMT_W-1:0] shamt;
    logic  cmp;
    logic  scmp;
    logic  padding;

    assign lui_imm = {ex_bundle.imm, 12'b0};
    assign s_imm   = {{(`XLEN-12){ex_bundle.imm[11]}}, ex_bundle.imm[11:0]};
    assign z_imm   = {{(`XLEN-12){1'b0}}, ex_bundle.imm[11:0]};
    assign op_imm  = ex_bundle.uext ? z_imm : s_imm;

    assign data1 = ex_bundle.rs1_data;
    assign data2 = ex_bundle.immv ? op_imm : ex_bundle.rs2_data;

    assign add_result = data1 + data2;
    assign sub_result = data1 - ex_bundle.rs2_data;  // No immediate form.

    assign cmp = data1 < data2;

    // Signed less-than from the two sign bits.
    always_comb begin
        case ({data1[`XLEN-1], data2[`XLEN-1]})
            2'b01:   scmp = 1'b0;
            2'b10:   scmp = 1'b1;
            default: scmp = cmp;
        endcase
    end

    assign shamt   = data2[SHAMT_W-1:0];
    assign padding = data1[`XLEN-1] & ~ex_bundle.uext;
    assign sl_data = data1 << shamt;

    // Each output bit picks its source bit or the fill bit.
    always_comb begin
        sr_data = '0;
        for (int i = 0; i < `XLEN; i++) begin
            if (i + int'(shamt) < `XLEN) begin
                sr_data[i] = data1[i + int'(shamt)];
            end else begin
                sr_data[i] = padding;
            end
        end
    end

    always_comb begin
        case (ex_bundle.intop)
            `INT_ADD: begin
                alu_result = add_result;
            end
            `INT_SUB: begin
                alu_result = sub_result;
            end
            `INT_LUI: begin
                alu_result = lui_imm;
            end
            `INT_SLT: begin
                alu_result = xlen_t'(ex_bundle.uext ? cmp : scmp);
            end
            `INT_OR: begin
                alu_result = data1 | data2;
            end
            `INT_XOR: begin
                alu_result = data1 ^ data2;
            end
            `INT_AND: begin
                alu_result = data1 & data2;
            end
            `INT_SL: begin
                alu_result = sl_data;
            end
            `INT_SR: begin
                alu_result = sr_data;
            end
            `INT_AUIPC: begin
                alu_result = ex_bundle.vaddr + lui_imm;  // PC relative.
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_macros.svh"

module branch_unit (
    input  exu_pkg::exu_bundle_t ex_bundle,
    output exu_pkg::xlen_t       br_result,
    output exu_pkg::branch_res_t br_res
);
    import exu_pkg::*;

    xlen_t  s_imm;
    vaddr_t br_target;
    vaddr_t jalr_target;
    vaddr_t link;
    logic   equal;
    logic   cmp;
    logic   scmp;
    logic   lt;
    logic   dir;
    logic   is_jal;
    logic   is_jalr;
    logic   stream_hit;
    logic   branch_error;
    logic   indirect_error;

    assign equal = ex_bundle.rs1_data == ex_bundle.rs2_data;
    assign cmp   = ex_bundle.rs1_data < ex_bundle.rs2_data;

    always_comb begin
        case ({ex_bundle.rs1_data[`XLEN-1], ex_bundle.rs2_data[`XLEN-1]})
            2'b01:   scmp = 1'b0;
            2'b10:   scmp = 1'b1;
            default: scmp = cmp;
        endcase
    end

    assign lt = ex_bundle.uext ? cmp : scmp;

    always_comb begin
        case (ex_bundle.branchop)
            `BRANCH_BEQ: dir = equal;
            `BRANCH_BNE: dir = ~equal;
            `BRANCH_BLT: dir = lt;
            `BRANCH_BGE: dir = ~lt;
            default:     dir = 1'b0;  // Jumps have no condition.
        endcase
    end

    assign is_jal  = ex_bundle.branchop == `BRANCH_JAL;
    assign is_jalr = ex_bundle.branchop == `BRANCH_JALR;

    // Offset in halfwords, so bit 0 is always clear.
    assign s_imm       = {{(`XLEN-12){ex_bundle.imm[11]}}, ex_bundle.imm[11:1], 1'b0};
    assign br_target   = ex_bundle.vaddr + s_imm;
    assign jalr_target = ex_bundle.rs1_data + s_imm;
    assign link        = ex_bundle.vaddr + `VADDR_SIZE'd4;

    assign br_result = link;

    // A hit means the predictor saw this slot as the block exit.
    assign stream_hit = ex_bundle.stream.size == ex_bundle.offset;

    assign branch_error = stream_hit ?
        (ex_bundle.stream.taken ^ dir) |
        (ex_bundle.stream.taken & (ex_bundle.stream.target != br_target)) :
        dir;
    assign indirect_error = ~stream_hit | (ex_bundle.stream.target != jalr_target);

    always_comb begin
        br_res.direction = is_jalr | dir;
        if (is_jalr) begin
            br_res.target = jalr_target;
        end else if (dir) begin
            br_res.target = br_target;
        end else begin
            br_res.target = link;
        end
        if (is_jalr) begin
            br_res.error = indirect_error;
        end else if (is_jal) begin
            br_res.error = 1'b0;
        end else begin
            br_res.error = branch_error;
        end
        br_res.br_type  = ex_bundle.br_type;
        br_res.ras_type = ex_bundle.ras_type;
    end

endmodule

`default_nettype wire

// File: wb_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_macros.svh"

module wb_stage (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ex_valid,
    input  exu_pkg::exu_bundle_t ex_bundle,
    input  exu_pkg::xlen_t       alu_result,
    input  exu_pkg::xlen_t       br_result,
    input  exu_pkg::branch_res_t br_res,
    output exu_pkg::wb_data_t    wb_data,
    output exu_pkg::branch_res_t branch_res,
    output logic                 branch_valid,
    output logic                 redirect
);
    import exu_pkg::*;

    logic        en_q;
    logic        we_q;
    rob_idx_t    rob_idx_q;
    reg_idx_t    rd_q;
    xlen_t       res_q;
    branch_res_t branch_res_q;
    logic        is_branch;

    assign is_branch = ex_valid & ~ex_bundle.intv;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_q         <= 1'b0;
            branch_valid <= 1'b0;
            redirect     <= 1'b0;
        end else begin
            en_q         <= ex_valid;
            branch_valid <= is_branch;
            redirect     <= is_branch & br_res.error;  // One pulse per miss.
        end
    end

    always_ff @(posedge clk) begin
        if (ex_valid) begin
            we_q      <= ex_bundle.we;
            rob_idx_q <= ex_bundle.rob_idx;
            rd_q      <= ex_bundle.rd;
            res_q     <= ex_bundle.intv ? alu_result : br_result;
        end
        if (is_branch) begin
            branch_res_q <= br_res;
        end
    end

    assign wb_data = '{en: en_q, we: we_q, rob_idx: rob_idx_q, rd: rd_q,
                       res: res_q, exccode: `EXC_NONE};

    assign branch_res = branch_res_q;

endmodule

`default_nettype wire

// File: exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue_valid,
    input  exu_pkg::exu_bundle_t issue_bundle,
    input  logic                 flush,
    output exu_pkg::wb_data_t    wb_data,
    output exu_pkg::branch_res_t branch_res,
    output logic                 branch_valid,
    output logic                 redirect
);
    import exu_pkg::*;

    logic        ex_valid;
    exu_bundle_t ex_bundle;
    xlen_t       alu_result;
    xlen_t       br_result;
    branch_res_t br_res;

    issue_stage i_issue_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_bundle (issue_bundle),
        .flush        (flush),
        .ex_valid     (ex_valid),
        .ex_bundle    (ex_bundle)
    );

    int_alu i_int_alu (
        .ex_bundle  (ex_bundle),
        .alu_result (alu_result)
    );

    branch_unit i_branch_unit (
        .ex_bundle (ex_bundle),
        .br_result (br_result),
        .br_res    (br_res)
    );

    wb_stage i_wb_stage (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_valid     (ex_valid),
        .ex_bundle    (ex_bundle),
        .alu_result   (alu_result),
        .br_result    (br_result),
        .br_res       (br_res),
        .wb_data      (wb_data),
        .branch_res   (branch_res),
        .branch_valid (branch_valid),
        .redirect     (redirect)
    );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD_NS = 4.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: exu_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module exu_assertions (
    input logic              clk,
    input logic              rst_n,
    input exu_pkg::wb_data_t wb_data,
    input logic              branch_valid,
    input logic              redirect
);

    int fail_count = 0;

    redirect_needs_branch: assert property (
        @(posedge clk) disable iff (!rst_n) redirect |-> branch_valid
    ) else begin
        fail_count++;
        $error("redirect high without branch_valid");
    end

    branch_needs_wb: assert property (
        @(posedge clk) disable iff (!rst_n) branch_valid |-> wb_data.en
    ) else begin
        fail_count++;
        $error("branch_valid high without wb_data.en");
    end

    // No strobe may leak out while the core is held in reset.
    idle_in_reset: assert property (
        @(posedge clk) !rst_n |-> !(wb_data.en || branch_valid || redirect)
    ) else begin
        fail_count++;
        $error("Output enable high during reset");
    end

endmodule

bind exu_top exu_assertions i_exu_assertions (
    .clk          (clk),
    .rst_n        (rst_n),
    .wb_data      (wb_data),
    .branch_valid (branch_valid),
    .redirect     (redirect)
);

`default_nettype wire

// File: exu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_macros.svh"

module exu_tb;
    import exu_pkg::*;

    localparam int NUM_OPS    = 57;
    localparam int MAX_CYCLES = NUM_OPS * 3 + 50;

    logic        clk;
    logic        rst_n;
    logic        issue_valid;
    exu_bundle_t issue_bundle;
    logic        flush;
    wb_data_t    wb_data;
    branch_res_t branch_res;
    logic        branch_valid;
    logic        redirect;
    logic [31:0] lfsr_state = 32'h91f3_8698;
    logic        last_redirect;
    int          cycle_count = 0;

    tb_clk_gen #(.PERIOD_NS(4.0)) i_clk_gen (.clk(clk));

    exu_top i_exu_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue_bundle (issue_bundle),
        .flush        (flush),
        .wb_data      (wb_data),
        .branch_res   (branch_res),
        .branch_valid (branch_valid),
        .redirect     (redirect)
    );

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("Timeout after %0d cycles", cycle_count);
            $display("Something failed");
            $fatal(1, "Run did not finish within the cycle limit");
        end else if (i_exu_top.i_exu_assertions.fail_count != 0) begin
            $display("An assertion on the DUT outputs failed");
            $display("Something failed");
            $fatal(1, "Stopped at the first assertion failure");
        end
    end

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value      = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic exu_bundle_t random_bundle();
        exu_bundle_t b;
        b.intv          = 1'b1;
        b.immv          = 1'b0;
        b.uext          = 1'b0;
        b.imm           = imm_t'(rand_bits(20));
        b.intop         = `INT_ADD;
        b.branchop      = `BRANCH_BEQ;
        b.offset        = offset_t'(rand_bits(3));
        b.we            = 1'(rand_bits(1));
        b.rob_idx       = rob_idx_t'(rand_bits(5));
        b.rd            = reg_idx_t'(rand_bits(5));
        b.rs1_data      = rand_bits(32);
        b.rs2_data      = rand_bits(32);
        b.vaddr         = rand_bits(32) & 32'hffff_fffc;
        b.stream.taken  = 1'(rand_bits(1));
        b.stream.size   = offset_t'(rand_bits(3));
        b.stream.target = rand_bits(32);
        b.br_type       = br_type_t'(rand_bits(2));
        b.ras_type      = ras_type_t'(rand_bits(2));
        return b;
    endfunction

    function automatic xlen_t model_res(input exu_bundle_t b);
        xlen_t      op2;
        xlen_t      upper;
        xlen_t      r;
        logic [4:0] sh;
        upper = {b.imm, 12'h000};
        if (!b.intv) begin
            return b.vaddr + 32'd4;  // Link value.
        end
        if (!b.immv) begin
            op2 = b.rs2_data;
        end else if (b.uext) begin
            op2 = {20'h0, b.imm[11:0]};
        end else begin
            op2 = xlen_t'($signed(b.imm[11:0]));
        end
        sh = op2[4:0];
        case (b.intop)
            `INT_ADD:   r = b.rs1_data + op2;
            `INT_SUB:   r = b.rs1_data - b.rs2_data;
            `INT_LUI:   r = upper;
            `INT_SLT:   r = b.uext ? xlen_t'(b.rs1_data < op2) :
                                     xlen_t'($signed(b.rs1_data) < $signed(op2));
            `INT_OR:    r = b.rs1_data | op2;
            `INT_XOR:   r = b.rs1_data ^ op2;
            `INT_AND:   r = b.rs1_data & op2;
            `INT_SL:    r = b.rs1_data << sh;
            `INT_SR: begin
                if (b.uext) begin
                    r = b.rs1_data >> sh;
                end else begin
                    r = $signed(b.rs1_data) >>> sh;
                end
            end
            `INT_AUIPC: r = b.vaddr + upper;
            default:    r = '0;
        endcase
        return r;
    endfunction

    function automatic branch_res_t model_branch(input exu_bundle_t b);
        branch_res_t br;
        xlen_t       off;
        vaddr_t      taken_target;
        vaddr_t      jalr_target;
        logic        cond;
        logic        hit;
        off          = xlen_t'($signed({b.imm[11:1], 1'b0}));
        taken_target = b.vaddr + off;
        jalr_target  = b.rs1_data + off;
        hit          = b.stream.size == b.offset;
        case (b.branchop)
            `BRANCH_BEQ: cond = b.rs1_data == b.rs2_data;
            `BRANCH_BNE: cond = b.rs1_data != b.rs2_data;
            `BRANCH_BLT: cond = b.uext ? b.rs1_data < b.rs2_data :
                                         $signed(b.rs1_data) < $signed(b.rs2_data);
            `BRANCH_BGE: cond = b.uext ? b.rs1_data >= b.rs2_data :
                                         $signed(b.rs1_data) >= $signed(b.rs2_data);
            default:     cond = 1'b0;
        endcase
        br.direction = cond || b.branchop == `BRANCH_JALR;
        if (b.branchop == `BRANCH_JALR) begin
            br.target = jalr_target;
            br.error  = !hit || b.stream.target != jalr_target;
        end else begin
            br.target = br.direction ? taken_target : b.vaddr + 32'd4;
            if (b.branchop == `BRANCH_JAL) begin
                br.error = 1'b0;
            end else if (hit) begin
                br.error = b.stream.taken != br.direction ||
                           (b.stream.taken && b.stream.target != taken_target);
            end else begin
                br.error = br.direction;
            end
        end
        br.br_type  = b.br_type;
        br.ras_type = b.ras_type;
        return br;
    endfunction

    task automatic check(input logic [63:0] actual, input logic [63:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("Error: %0d ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Something failed");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_outputs(input exu_bundle_t b);
        branch_res_t exp_br;
        exp_br = model_branch(b);
        check(wb_data.en, 1'b1, "wb_data.en");
        check(wb_data.we, b.we, "wb_data.we");
        check(wb_data.rob_idx, b.rob_idx, "wb_data.rob_idx");
        check(wb_data.rd, b.rd, "wb_data.rd");
        check(wb_data.res, model_res(b), "wb_data.res");
        check(wb_data.exccode, `EXC_NONE, "wb_data.exccode");
        check(branch_valid, !b.intv, "branch_valid");
        if (!b.intv) begin
            check(branch_res, exp_br, "branch_res");
            check(redirect, exp_br.error, "redirect");
        end else begin
            check(redirect, 1'b0, "redirect");
        end
    endtask

    // Result shows two edges after issue, then the strobes drop again.
    task automatic issue_and_check(input exu_bundle_t b);
        issue_bundle = b;
        issue_valid  = 1'b1;
        next_cycle();
        issue_valid = 1'b0;
        next_cycle();
        check_outputs(b);
        last_redirect = redirect;
        next_cycle();
        check(wb_data.en, 1'b0, "wb_data.en one cycle after the result");
        check(redirect, 1'b0, "redirect one cycle after the result");
    endtask

    task automatic issue_imm_op(input intop_t op, input logic uext, input imm_t imm,
                                input xlen_t rs1);
        exu_bundle_t b;
        b          = random_bundle();
        b.immv     = 1'b1;
        b.intop    = op;
        b.uext     = uext;
        b.imm      = imm;
        b.rs1_data = rs1;
        issue_and_check(b);
    endtask

    task automatic alu_reg_ops();
        exu_bundle_t b;
        intop_t      ops[7] = '{`INT_ADD, `INT_SUB, `INT_OR, `INT_XOR, `INT_AND,
                                `INT_SLT, `INT_SLT};
        for (int rep = 0; rep < 2; rep++) begin
            for (int i = 0; i < 7; i++) begin
                b       = random_bundle();
                b.intop = ops[i];
                b.uext  = i == 6;  // Unsigned SLT.
                issue_and_check(b);
            end
        end
    endtask

    task automatic alu_imm_ops();
        xlen_t neg;
        imm_t  shamts[3] = '{20'd0, 20'd1, 20'd31};
        neg = rand_bits(32) | 32'h8000_0000;
        issue_imm_op(`INT_ADD, 1'b0, 20'h00ffb, rand_bits(32));  // ADDI -5.
        issue_imm_op(`INT_SLT, 1'b1, 20'h00800, 32'd3000);  // Above 2048, below -2048.
        issue_imm_op(`INT_LUI, 1'b0, 20'habcde, rand_bits(32));
        issue_imm_op(`INT_AUIPC, 1'b0, imm_t'(rand_bits(20)), rand_bits(32));
        for (int i = 0; i < 3; i++) begin
            issue_imm_op(`INT_SL, 1'b0, shamts[i], neg);
            issue_imm_op(`INT_SR, 1'b1, shamts[i], neg);
            issue_imm_op(`INT_SR, 1'b0, shamts[i], neg);
        end
    endtask

    task automatic branch_conditions();
        exu_bundle_t b;
        branchop_t   bops[4] = '{`BRANCH_BEQ, `BRANCH_BNE, `BRANCH_BLT, `BRANCH_BGE};
        for (int i = 0; i < 4; i++) begin
            for (int k = 0; k < 4; k++) begin
                b          = random_bundle();
                b.intv     = 1'b0;
                b.branchop = bops[i];
                b.uext     = k[0];
                if (k < 2) begin
                    b.rs2_data = b.rs1_data;
                end else begin
                    b.rs1_data = b.rs1_data | 32'h8000_0000;  // Negative against positive.
                    b.rs2_data = b.rs2_data & 32'h7fff_ffff;
                end
                issue_and_check(b);
            end
        end
    endtask

    task automatic mispredictions();
        exu_bundle_t b0;
        exu_bundle_t b;
        b0               = random_bundle();
        b0.intv          = 1'b0;
        b0.imm           = 20'h00010;
        b0.rs2_data      = b0.rs1_data;
        b0.offset        = 3'd2;
        b0.stream.size   = 3'd2;
        b0.stream.taken  = 1'b1;
        b0.stream.target = b0.vaddr + 32'd16;
        issue_and_check(b0);
        check(last_redirect, 1'b0, "redirect for a correct prediction");
        b          = b0;
        b.rs2_data = b0.rs1_data + 32'd1;
        issue_and_check(b);
        check(last_redirect, 1'b1, "redirect for a wrong direction");
        b               = b0;
        b.stream.target = b0.vaddr + 32'd20;
        issue_and_check(b);
        check(last_redirect, 1'b1, "redirect for a wrong target");
        b             = b0;
        b.stream.size = 3'd5;
        issue_and_check(b);
        check(last_redirect, 1'b1, "redirect for a stream miss");
        b.branchop = `BRANCH_JAL;
        issue_and_check(b);
        check(last_redirect, 1'b0, "redirect for JAL");
        b               = b0;
        b.branchop      = `BRANCH_JALR;
        b.stream.target = b0.rs1_data + 32'd16;
        issue_and_check(b);
        check(last_redirect, 1'b0, "redirect for a correct JALR");
        b.stream.target = b0.rs1_data + 32'd8;
        issue_and_check(b);
        check(last_redirect, 1'b1, "redirect for a JALR target mismatch");
    endtask

    task automatic pipelining();
        exu_bundle_t ops[4];
        for (int i = 0; i < 4; i++) begin
            ops[i]       = random_bundle();
            ops[i].intv  = i != 2;  // One branch in the middle.
            ops[i].intop = `INT_XOR;
        end
        for (int c = 0; c < 6; c++) begin
            issue_valid = c < 4;
            if (c < 4) begin
                issue_bundle = ops[c];
            end
            if (c >= 2) begin
                check_outputs(ops[c - 2]);
            end
            next_cycle();
        end
        check(wb_data.en, 1'b0, "wb_data.en after the burst");
    endtask

    task automatic flushing();
        exu_bundle_t a;
        exu_bundle_t b;
        a            = random_bundle();
        b            = random_bundle();
        issue_bundle = a;
        issue_valid  = 1'b1;
        flush        = 1'b1;
        next_cycle();
        issue_valid = 1'b0;
        flush       = 1'b0;
        next_cycle();
        check(wb_data.en, 1'b0, "wb_data.en for an op issued with flush");
        next_cycle();
        check(wb_data.en, 1'b0, "wb_data.en for an op issued with flush");
        // The flush edge drops both the held op and the new one.
        issue_valid = 1'b1;
        next_cycle();
        issue_bundle = b;
        flush        = 1'b1;
        next_cycle();
        issue_valid = 1'b0;
        flush       = 1'b0;
        check(wb_data.en, 1'b0, "wb_data.en for an op held at a flush");
        next_cycle();
        check(wb_data.en, 1'b0, "wb_data.en for an op flushed at issue");
    endtask

    initial begin
        rst_n         = 1'b0;
        issue_valid   = 1'b0;
        issue_bundle  = '0;
        flush         = 1'b0;
        last_redirect = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        next_cycle();
        alu_reg_ops();
        alu_imm_ops();
        branch_conditions();
        mispredictions();
        pipelining();
        flushing();
        if (i_exu_top.i_exu_assertions.fail_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("%0d assertion failures", i_exu_top.i_exu_assertions.fail_count);
            $display("Something failed");
            $fatal(1, "Assertions failed during the run");
        end
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+.
exu_pkg.sv
issue_stage.sv
int_alu.sv
branch_unit.sv
wb_stage.sv
exu_top.sv
tb_clk_gen.sv
exu_assertions.sv
exu_tb.sv

// File: Bender.yml
package:
  name: exu

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - exu_pkg.sv
      - issue_stage.sv
      - int_alu.sv
      - branch_unit.sv
      - wb_stage.sv
      - exu_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - exu_assertions.sv
      - exu_tb.sv
